// File: hw/conv_pkg.sv
package conv_pkg;

    // element and word geometry
    localparam int DATA_W = 8;
    localparam int LANES  = 4;
    localparam int NUM_PE = 4;

    // memory sizes
    localparam int IFM_DEPTH  = 256;
    localparam int IFM_ADDR_W = 8;
    localparam int WGT_DEPTH  = 16;
    localparam int WGT_ADDR_W = 4;
    // zero bits above a weight address on the shared ram port
    localparam int WGT_PAD_W  = IFM_ADDR_W - WGT_ADDR_W;

    // accumulate and requantize
    localparam int ACC_W     = 24;
    localparam int OUT_SHIFT = 6;
    localparam int OFM_MAX   = 127;
    localparam int OFM_MIN   = -128;

    typedef logic signed [DATA_W-1:0] data8_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // lane 0 sits in the low byte
    typedef data8_t    [LANES-1:0]  ifm_word_t;
    // element p feeds output channel p
    typedef ifm_word_t [NUM_PE-1:0] weight_bank_t;
    typedef data8_t    [NUM_PE-1:0] ofm_vec_t;

    typedef struct packed {
        logic [IFM_ADDR_W-1:0] num_pixels;
        logic [WGT_ADDR_W-1:0] chan_words;
    } conv_cfg_t;

    typedef struct packed {
        logic                  en;
        logic [IFM_ADDR_W-1:0] addr;
        ifm_word_t             data;
    } ifm_write_t;

    typedef struct packed {
        logic                  en;
        logic [WGT_ADDR_W-1:0] addr;
        weight_bank_t          data;
    } wgt_write_t;

    // one accumulation step lined up with ram read data
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } step_t;

endpackage

// File: hw/word_ram.sv
`timescale 1ns/10ps

module word_ram import conv_pkg::*; #(
    parameter type payload_t = ifm_word_t
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [IFM_ADDR_W-1:0] wr_addr,
    input  payload_t              wr_data,
    input  logic [IFM_ADDR_W-1:0] rd_addr,
    output payload_t              rd_data
);

    payload_t mem [IFM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read gives data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hw/conv_addr_gen.sv
`timescale 1ns/10ps

module conv_addr_gen import conv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    input  conv_cfg_t             cfg,
    output logic [IFM_ADDR_W-1:0] ifm_rd_addr,
    output logic [WGT_ADDR_W-1:0] wgt_rd_addr,
    output step_t                 step,
    output logic                  busy,
    output logic                  done
);

    conv_cfg_t             cfg_q;
    logic                  accept;
    logic                  start;
    logic                  issuing;
    logic [WGT_ADDR_W-1:0] word;
    logic [IFM_ADDR_W-1:0] pixel;
    logic [IFM_ADDR_W-1:0] base;
    logic                  word_end;
    logic                  layer_end;
    step_t                 rd_step;
    logic                  rd_final;
    logic                  step_final;
    logic                  tail;

    // a run during start or busy is dropped
    assign accept    = run && !busy && !start;
    assign word_end  = (word == cfg_q.chan_words - 1'b1);
    assign layer_end = word_end && (pixel == cfg_q.num_pixels - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q      <= '0;
            start      <= 1'b0;
            issuing    <= 1'b0;
            busy       <= 1'b0;
            word       <= '0;
            pixel      <= '0;
            base       <= '0;
            rd_step    <= '0;
            rd_final   <= 1'b0;
            step       <= '0;
            step_final <= 1'b0;
            tail       <= 1'b0;
            done       <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                cfg_q <= cfg;
            end

            if (start) begin
                issuing <= 1'b1;
                busy    <= 1'b1;
                word    <= '0;
                pixel   <= '0;
                base    <= '0;
            end else if (issuing) begin
                if (word_end) begin
                    word  <= '0;
                    pixel <= pixel + 1'b1;
                    // running base replaces pixel * chan_words
                    base  <= base + cfg_q.chan_words;
                    if (layer_end) begin
                        issuing <= 1'b0;
                    end
                end else begin
                    word <= word + 1'b1;
                end
            end

            // flags travel with the address register
            rd_step.valid <= issuing;
            rd_step.first <= issuing && (word == '0);
            rd_step.last  <= issuing && word_end;
            rd_final      <= issuing && layer_end;

            // one more stage for the ram read latency
            step       <= rd_step;
            step_final <= rd_final;

            // tail lines up with the final ofm_valid and done follows
            tail <= step_final;
            done <= tail;
            if (tail) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        ifm_rd_addr <= base + IFM_ADDR_W'(word);
        wgt_rd_addr <= word;
    end

endmodule

// File: hw/pe_cluster.sv
`timescale 1ns/10ps

module pe_cluster import conv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  step_t        step,
    input  ifm_word_t    ifm,
    input  weight_bank_t weights,
    output ofm_vec_t     ofm,
    output logic         ofm_valid
);

    // saturated result of every lane taken on a last step
    ofm_vec_t sat_vec;

    for (genvar p = 0; p < NUM_PE; p++) begin : g_lane
        acc_t dot;
        acc_t acc;
        acc_t total;
        acc_t scaled;

        // four signed byte products of this word
        always_comb begin
            logic signed [2*DATA_W-1:0] prod;
            dot = '0;
            for (int l = 0; l < LANES; l++) begin
                prod = ifm[l] * weights[p][l];
                dot  = dot + prod;
            end
        end

        // first step of a pixel restarts the sum
        assign total  = step.first ? dot : acc + dot;
        assign scaled = total >>> OUT_SHIFT;

        always_ff @(posedge clk) begin
            if (step.valid) begin
                acc <= total;
            end
        end

        // clamp to the signed byte range
        assign sat_vec[p] = (scaled > OFM_MAX) ? data8_t'(OFM_MAX) :
                            (scaled < OFM_MIN) ? data8_t'(OFM_MIN) :
                            scaled[DATA_W-1:0];
    end

    // output register holds until the next pixel ends
    always_ff @(posedge clk) begin
        if (step.valid && step.last) begin
            ofm <= sat_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ofm_valid <= 1'b0;
        end else begin
            ofm_valid <= step.valid && step.last;
        end
    end

endmodule

// File: hw/conv_top.sv
`timescale 1ns/10ps

module conv_top import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ifm_write_t ifm_wr,
    input  wgt_write_t wgt_wr,
    input  logic       run,
    input  conv_cfg_t  cfg,
    output ofm_vec_t   ofm,
    output logic       ofm_valid,
    output logic       busy,
    output logic       done
);

    logic [IFM_ADDR_W-1:0] ifm_rd_addr;
    logic [WGT_ADDR_W-1:0] wgt_rd_addr;
    ifm_word_t             ifm_data;
    weight_bank_t          wgt_data;
    step_t                 step;

    // input feature map with one word per channel group of a pixel
    word_ram ifm_ram (
        .clk     (clk),
        .wr_en   (ifm_wr.en),
        .wr_addr (ifm_wr.addr),
        .wr_data (ifm_wr.data),
        .rd_addr (ifm_rd_addr),
        .rd_data (ifm_data)
    );

    // weight banks with one entry per channel group for all PEs
    word_ram #(
        .payload_t (weight_bank_t)
    ) wgt_ram (
        .clk     (clk),
        .wr_en   (wgt_wr.en),
        .wr_addr ({{WGT_PAD_W{1'b0}}, wgt_wr.addr}),
        .wr_data (wgt_wr.data),
        .rd_addr ({{WGT_PAD_W{1'b0}}, wgt_rd_addr}),
        .rd_data (wgt_data)
    );

    conv_addr_gen addr_gen (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .cfg         (cfg),
        .ifm_rd_addr (ifm_rd_addr),
        .wgt_rd_addr (wgt_rd_addr),
        .step        (step),
        .busy        (busy),
        .done        (done)
    );

    pe_cluster pe_array (
        .clk       (clk),
        .rst       (rst),
        .step      (step),
        .ifm       (ifm_data),
        .weights   (wgt_data),
        .ofm       (ofm),
        .ofm_valid (ofm_valid)
    );

endmodule

// File: bench/conv_asserts.sv
`timescale 1ns/10ps

module conv_asserts import conv_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      run,
    input conv_cfg_t cfg,
    input logic      ofm_valid,
    input logic      busy,
    input logic      done
);

    // an accepted run carries a usable layer shape
    assert property (@(posedge clk) disable iff (rst)
        (run && !busy) |-> (cfg.num_pixels != '0 && cfg.chan_words != '0))
        else $error("run accepted with a zero cfg field");

    // results only come out during a layer
    assert property (@(posedge clk) disable iff (rst)
        ofm_valid |-> busy)
        else $error("ofm_valid high while busy is low");

    // done lasts one cycle and busy drops with it
    assert property (@(posedge clk) disable iff (rst)
        done |-> ($fell(busy) ##1 !done))
        else $error("done is not a single pulse at the fall of busy");

endmodule

bind conv_top conv_asserts conv_asserts_inst (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .cfg       (cfg),
    .ofm_valid (ofm_valid),
    .busy      (busy),
    .done      (done)
);

// File: bench/conv_tb.sv
`timescale 1ns/10ps

module conv_tb import conv_pkg::*; ();

    logic       clk;
    logic       rst;
    ifm_write_t ifm_wr;
    wgt_write_t wgt_wr;
    logic       run;
    conv_cfg_t  cfg;
    ofm_vec_t   ofm;
    logic       ofm_valid;
    logic       busy;
    logic       done;

    // mirrors of the DUT memories
    ifm_word_t    ifm_mem [IFM_DEPTH];
    weight_bank_t wgt_mem [WGT_DEPTH];
    ofm_vec_t     exp_q [$];
    ofm_vec_t     expected;
    logic [31:0]  lcg_state = 32'hddd93de6;
    string        test_name = "reset";
    int           pulse_count = 0;
    int           mismatch_count = 0;
    int           timeout_count = 0;
    int           other_count = 0;

    conv_top conv_top_inst (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected result of one pixel by multiply, shift and clamp
    function automatic ofm_vec_t model_pixel(input int pixel, input int cw);
        ofm_vec_t result;
        int       sum;
        int       a;
        int       b;
        for (int p = 0; p < NUM_PE; p++) begin
            sum = 0;
            for (int w = 0; w < cw; w++) begin
                for (int l = 0; l < LANES; l++) begin
                    a = $signed(ifm_mem[pixel * cw + w][l]);
                    b = $signed(wgt_mem[w][p][l]);
                    sum += a * b;
                end
            end
            sum = sum >>> OUT_SHIFT;
            if (sum > 127) begin
                result[p] = 8'sd127;
            end else if (sum < -128) begin
                result[p] = -8'sd128;
            end else begin
                result[p] = sum[7:0];
            end
        end
        return result;
    endfunction

    // mode 0 random, 1 all 127, 2 ifm at -128 against weights at 127
    task automatic fill_memories(input conv_cfg_t c, input int mode);
        ifm_word_t    word;
        weight_bank_t bank;
        for (int i = 0; i < c.num_pixels * c.chan_words; i++) begin
            word = (mode == 0) ? ifm_word_t'(next_random()) :
                   (mode == 1) ? 32'h7f7f7f7f : 32'h80808080;
            @(posedge clk);
            #5;
            ifm_wr = '{en: 1'b1, addr: i[IFM_ADDR_W-1:0], data: word};
            ifm_mem[i] = word;
        end
        for (int w = 0; w < c.chan_words; w++) begin
            for (int p = 0; p < NUM_PE; p++) begin
                bank[p] = (mode == 0) ? ifm_word_t'(next_random()) : 32'h7f7f7f7f;
            end
            @(posedge clk);
            #5;
            ifm_wr.en = 1'b0;
            wgt_wr = '{en: 1'b1, addr: w[WGT_ADDR_W-1:0], data: bank};
            wgt_mem[w] = bank;
        end
        @(posedge clk);
        #5;
        ifm_wr.en = 1'b0;
        wgt_wr.en = 1'b0;
    endtask

    task automatic pulse_run(input conv_cfg_t c);
        @(posedge clk);
        #5;
        run = 1'b1;
        cfg = c;
        @(posedge clk);
        #5;
        run = 1'b0;
    endtask

    task automatic wait_for_level(input bit want_done, input int limit);
        int cycles;
        cycles = 0;
        while ((want_done ? !done : !busy) && cycles < limit) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        assert (want_done ? done : busy) else begin
            timeout_count++;
            $display("ERROR: %s: %s did not rise within %0d cycles", test_name,
                     want_done ? "done" : "busy", limit);
        end
    endtask

    task automatic run_layer(input string name, input conv_cfg_t c, input int mode,
                             input bit extra_run);
        conv_cfg_t other;
        test_name = name;
        fill_memories(c, mode);
        for (int px = 0; px < c.num_pixels; px++) begin
            exp_q.push_back(model_pixel(px, c.chan_words));
        end
        pulse_count = 0;
        pulse_run(c);
        if (extra_run) begin
            // a second run in the middle of the layer must be dropped
            wait_for_level(1'b0, 20);
            repeat (2) @(posedge clk);
            other = '{num_pixels: 8'd9, chan_words: 4'd2};
            pulse_run(other);
        end
        wait_for_level(1'b1, 1000);
        assert (pulse_count == c.num_pixels) else begin
            mismatch_count++;
            $display("MISMATCH %s pulse count: expected %0d actual %0d", test_name,
                     c.num_pixels, pulse_count);
        end
        assert (!busy) else begin
            other_count++;
            $display("ERROR: %s: busy still high in the done cycle", test_name);
        end
        exp_q.delete();
    endtask

    // take each result in the middle of its valid cycle
    always @(negedge clk) begin
        if (!rst && ofm_valid) begin
            pulse_count++;
            assert (exp_q.size() > 0) else begin
                other_count++;
                $display("ERROR: %s: ofm_valid with no result left to expect", test_name);
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (ofm == expected) else begin
                    mismatch_count++;
                    $display("MISMATCH %s: expected %h actual %h", test_name, expected, ofm);
                end
            end
        end
    end

    initial begin
        conv_cfg_t c;
        clk    = 1'b0;
        rst    = 1'b1;
        ifm_wr = '0;
        wgt_wr = '0;
        run    = 1'b0;
        cfg    = '0;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        c = '{num_pixels: 8'(4 + (next_random() >> 8) % 20), chan_words: 4'd1};
        run_layer("single_word", c, 0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            c.chan_words = 4'(2 + (next_random() >> 8) % 14);
            c.num_pixels = 8'(1 + (next_random() >> 8) % 16);
            run_layer("multi_word", c, 0, 1'b0);
        end
        c = '{num_pixels: 8'd4, chan_words: 4'd3};
        run_layer("saturate_high", c, 1, 1'b0);
        run_layer("saturate_low", c, 2, 1'b0);
        c = '{num_pixels: 8'd6, chan_words: 4'd4};
        run_layer("run_while_busy", c, 0, 1'b1);
        for (int i = 0; i < 3; i++) begin
            c.chan_words = 4'(1 + (next_random() >> 8) % 15);
            c.num_pixels = 8'(1 + (next_random() >> 8) % 16);
            run_layer("back_to_back", c, 0, 1'b0);
        end

        $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatch_count,
                 timeout_count, other_count);
        if (mismatch_count + timeout_count + other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: conv_accel.f
hw/conv_pkg.sv
hw/word_ram.sv
hw/conv_addr_gen.sv
hw/pe_cluster.sv
hw/conv_top.sv
bench/conv_asserts.sv
bench/conv_tb.sv
